// ==== source/fifo_defines.svh ====
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// Width of one FIFO word
`define FIFO_DATA_WID 16

// Number of entries in the storage array
`define FIFO_DEPTH 8

// Storage address width
`define FIFO_PTR_WID 3

// Count width, room for DEPTH+1 with the output stage word
`define FIFO_CNT_WID 4

// APB address width
`define APB_ADDR_WID 4

`endif

// ==== source/fifo_pkg.sv ====
`include "fifo_defines.svh"

package fifo_pkg;

    // -------------------------------------------------------------------------
    // Data and pointer types
    // -------------------------------------------------------------------------
    typedef logic [`FIFO_DATA_WID-1:0] data_t;

    typedef logic [`FIFO_PTR_WID-1:0] ptr_t;

    // Occupancy count
    typedef logic [`FIFO_CNT_WID-1:0] cnt_t;

    // -------------------------------------------------------------------------
    // Register block types
    // -------------------------------------------------------------------------
    typedef logic [31:0] apb_word_t;

    // Register offsets
    typedef enum logic [`APB_ADDR_WID-1:0] {
        REG_CONTROL = 4'h0,
        REG_INFO    = 4'h4,
        REG_DEPTH   = 4'h8,
        REG_STATUS  = 4'hC
    } reg_addr_e;

endpackage : fifo_pkg

// ==== source/fifo_reg_decode.sv ====
`timescale 1ns/1ps
`include "fifo_defines.svh"

module fifo_reg_decode (
    input  logic                     rd_clk,
    input  logic                     local_rd_srst,

    // APB slave
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`APB_ADDR_WID-1:0] paddr,
    input  fifo_pkg::apb_word_t      pwdata,
    output fifo_pkg::apb_word_t      prdata,
    output logic                     pready,
    output logic                     pslverr,

    // Live FIFO status
    input  fifo_pkg::cnt_t           rd_count,
    input  fifo_pkg::cnt_t           wr_count,
    input  logic                     wr_full,
    input  logic                     rd_empty,
    input  logic                     wr_oflow,
    input  logic                     rd_uflow,

    output logic                     soft_rst
);

    logic access;
    logic wr_access;
    logic addr_valid;
    logic status_clr;
    logic oflow_sticky;
    logic uflow_sticky;

    fifo_pkg::apb_word_t status_word;

    // -------------------------------------------------------------------------
    // Access decode
    // -------------------------------------------------------------------------
    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    // No wait states
    assign pready = 1'b1;

    assign status_clr = wr_access && (paddr == fifo_pkg::REG_STATUS);

    // Status fields packed at their fixed bit positions
    always_comb begin
        status_word      = '0;
        status_word[3:0] = rd_count;
        status_word[11:8] = wr_count;
        status_word[16]  = wr_full;
        status_word[17]  = rd_empty;
        status_word[24]  = oflow_sticky;
        status_word[25]  = uflow_sticky;
    end

    // Read mux and address check
    always_comb begin
        prdata     = '0;
        addr_valid = 1'b1;
        case (paddr)
            fifo_pkg::REG_CONTROL: prdata = '0;
            // FWFT, overflow protect, underflow protect
            fifo_pkg::REG_INFO:    prdata = 32'h0000_0007;
            fifo_pkg::REG_DEPTH:   prdata = fifo_pkg::apb_word_t'(`FIFO_DEPTH);
            fifo_pkg::REG_STATUS:  prdata = status_word;
            default:               addr_valid = 1'b0;
        endcase
    end

    assign pslverr = access && !addr_valid;

    // -------------------------------------------------------------------------
    // Sticky flags and soft reset
    // -------------------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            oflow_sticky <= 1'b0;
            uflow_sticky <= 1'b0;
        end else begin
            // A new strobe wins over a clear in the same cycle
            oflow_sticky <= (oflow_sticky && !status_clr) || wr_oflow;
            uflow_sticky <= (uflow_sticky && !status_clr) || rd_uflow;
        end
    end

    // One-cycle pulse
    always_ff @(posedge rd_clk) begin
        if (local_rd_srst) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= wr_access && (paddr == fifo_pkg::REG_CONTROL) && pwdata[0];
        end
    end

endmodule : fifo_reg_decode

// ==== source/fifo_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_defines.svh"

module fifo_ctrl (
    input  logic             rd_clk,
    input  logic             core_srst,

    // Write side
    input  logic             wr,
    output logic             mem_wr_en,
    output fifo_pkg::ptr_t   mem_wr_ptr,
    output logic             wr_full,
    output logic             wr_oflow,

    // Prefetch side
    input  logic             pre_rd,
    output logic             mem_rd_en,
    output fifo_pkg::ptr_t   mem_rd_ptr,
    output logic             mem_empty,

    output fifo_pkg::cnt_t   mem_count
);

    fifo_pkg::ptr_t wr_ptr;
    fifo_pkg::ptr_t rd_ptr;
    fifo_pkg::cnt_t count;

    // Wrap at the last entry, so a depth that is not a power of two also works
    function automatic fifo_pkg::ptr_t next_ptr(input fifo_pkg::ptr_t ptr);
        fifo_pkg::ptr_t last;
        last = fifo_pkg::ptr_t'(`FIFO_DEPTH - 1);
        if (ptr == last) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // -------------------------------------------------------------------------
    // Flags and protection
    // -------------------------------------------------------------------------
    assign wr_full   = (count == fifo_pkg::cnt_t'(`FIFO_DEPTH));
    assign mem_empty = (count == '0);

    // Overflow protection, writes while full are dropped
    assign mem_wr_en = wr && !wr_full;
    assign wr_oflow  = wr && wr_full;

    // Prefetch granted only with data present
    assign mem_rd_en = pre_rd && !mem_empty;

    assign mem_wr_ptr = wr_ptr;
    assign mem_rd_ptr = rd_ptr;
    assign mem_count  = count;

    // -------------------------------------------------------------------------
    // Pointers
    // -------------------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (core_srst) begin
            wr_ptr <= '0;
        end else if (mem_wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
    end

    always_ff @(posedge rd_clk) begin
        if (core_srst) begin
            rd_ptr <= '0;
        end else if (mem_rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
    end

    // -------------------------------------------------------------------------
    // Occupancy count
    // -------------------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (core_srst) begin
            count <= '0;
        end else begin
            case ({mem_wr_en, mem_rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // Simultaneous write and read leave it unchanged
                default: count <= count;
            endcase
        end
    end

endmodule : fifo_ctrl

// ==== source/fifo_mem.sv ====
`timescale 1ns/1ps
`include "fifo_defines.svh"

module fifo_mem (
    input  logic             rd_clk,

    // Write port
    input  logic             mem_wr_en,
    input  fifo_pkg::ptr_t   mem_wr_ptr,
    input  fifo_pkg::data_t  wr_data,

    // Read port, one cycle latency
    input  logic             mem_rd_en,
    input  fifo_pkg::ptr_t   mem_rd_ptr,
    output fifo_pkg::data_t  mem_rd_data
);

    fifo_pkg::data_t mem [`FIFO_DEPTH];

    // -------------------------------------------------------------------------
    // Storage array
    // -------------------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (mem_wr_en) begin
            mem[mem_wr_ptr] <= wr_data;
        end
    end

    // Output register holds its word until the next read
    always_ff @(posedge rd_clk) begin
        if (mem_rd_en) begin
            mem_rd_data <= mem[mem_rd_ptr];
        end
    end

endmodule : fifo_mem

// ==== source/fifo_fwft_out.sv ====
`timescale 1ns/1ps

module fifo_fwft_out (
    input  logic             rd_clk,
    input  logic             core_srst,

    // Consumer side
    input  logic             rd,
    output logic             rd_ack,
    output fifo_pkg::data_t  rd_data,
    output logic             rd_empty,
    output fifo_pkg::cnt_t   rd_count,
    output logic             rd_uflow,

    // Controller and memory side
    output logic             pre_rd,
    input  logic             mem_empty,
    input  fifo_pkg::cnt_t   mem_count,
    input  fifo_pkg::data_t  mem_rd_data
);

    logic head_vld;
    logic fetch;

    // -------------------------------------------------------------------------
    // Prefetch
    // -------------------------------------------------------------------------
    // Refill when the stage is empty or its word is being taken
    assign pre_rd = !head_vld || rd;
    assign fetch  = pre_rd && !mem_empty;

    // Head word valid once the memory has returned it
    always_ff @(posedge rd_clk) begin
        if (core_srst) begin
            head_vld <= 1'b0;
        end else if (fetch) begin
            head_vld <= 1'b1;
        end else if (rd) begin
            head_vld <= 1'b0;
        end
    end

    // -------------------------------------------------------------------------
    // Consumer outputs
    // -------------------------------------------------------------------------
    // Memory read register doubles as the head word store
    assign rd_data  = mem_rd_data;
    assign rd_empty = !head_vld;
    assign rd_ack   = head_vld;

    assign rd_uflow = rd && !head_vld;

    // Held word counts on top of the memory occupancy
    assign rd_count = mem_count + fifo_pkg::cnt_t'(head_vld);

endmodule : fifo_fwft_out

// ==== source/fifo_core.sv ====
`timescale 1ns/1ps
`include "fifo_defines.svh"

module fifo_core (
    input  logic                     rd_clk,
    input  logic                     local_rd_srst,

    // Write side
    input  logic                     wr,
    input  fifo_pkg::data_t          wr_data,
    output logic                     wr_full,
    output fifo_pkg::cnt_t           wr_count,
    output logic                     wr_oflow,

    // Read side
    input  logic                     rd,
    output logic                     rd_ack,
    output fifo_pkg::data_t          rd_data,
    output logic                     rd_empty,
    output fifo_pkg::cnt_t           rd_count,
    output logic                     rd_uflow,

    // APB control and monitoring
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`APB_ADDR_WID-1:0] paddr,
    input  fifo_pkg::apb_word_t      pwdata,
    output fifo_pkg::apb_word_t      prdata,
    output logic                     pready,
    output logic                     pslverr
);

    logic            soft_rst;
    logic            core_srst;

    logic            mem_wr_en;
    fifo_pkg::ptr_t  mem_wr_ptr;
    logic            mem_rd_en;
    fifo_pkg::ptr_t  mem_rd_ptr;
    fifo_pkg::data_t mem_rd_data;
    fifo_pkg::cnt_t  mem_count;
    logic            mem_empty;
    logic            pre_rd;

    // -------------------------------------------------------------------------
    // Resets
    // -------------------------------------------------------------------------
    // Register block stays on the external reset only
    assign core_srst = local_rd_srst || soft_rst;

    assign wr_count = mem_count;

    fifo_reg_decode u_reg_decode (
        .rd_clk        ( rd_clk ),
        .local_rd_srst ( local_rd_srst ),
        .psel          ( psel ),
        .penable       ( penable ),
        .pwrite        ( pwrite ),
        .paddr         ( paddr ),
        .pwdata        ( pwdata ),
        .prdata        ( prdata ),
        .pready        ( pready ),
        .pslverr       ( pslverr ),
        .rd_count      ( rd_count ),
        .wr_count      ( mem_count ),
        .wr_full       ( wr_full ),
        .rd_empty      ( rd_empty ),
        .wr_oflow      ( wr_oflow ),
        .rd_uflow      ( rd_uflow ),
        .soft_rst      ( soft_rst )
    );

    // -------------------------------------------------------------------------
    // Datapath
    // -------------------------------------------------------------------------
    fifo_ctrl u_ctrl (
        .rd_clk     ( rd_clk ),
        .core_srst  ( core_srst ),
        .wr         ( wr ),
        .mem_wr_en  ( mem_wr_en ),
        .mem_wr_ptr ( mem_wr_ptr ),
        .wr_full    ( wr_full ),
        .wr_oflow   ( wr_oflow ),
        .pre_rd     ( pre_rd ),
        .mem_rd_en  ( mem_rd_en ),
        .mem_rd_ptr ( mem_rd_ptr ),
        .mem_empty  ( mem_empty ),
        .mem_count  ( mem_count )
    );

    fifo_mem u_mem (
        .rd_clk      ( rd_clk ),
        .mem_wr_en   ( mem_wr_en ),
        .mem_wr_ptr  ( mem_wr_ptr ),
        .wr_data     ( wr_data ),
        .mem_rd_en   ( mem_rd_en ),
        .mem_rd_ptr  ( mem_rd_ptr ),
        .mem_rd_data ( mem_rd_data )
    );

    fifo_fwft_out u_fwft_out (
        .rd_clk      ( rd_clk ),
        .core_srst   ( core_srst ),
        .rd          ( rd ),
        .rd_ack      ( rd_ack ),
        .rd_data     ( rd_data ),
        .rd_empty    ( rd_empty ),
        .rd_count    ( rd_count ),
        .rd_uflow    ( rd_uflow ),
        .pre_rd      ( pre_rd ),
        .mem_empty   ( mem_empty ),
        .mem_count   ( mem_count ),
        .mem_rd_data ( mem_rd_data )
    );

endmodule : fifo_core

// ==== sim/tb_fifo_checks.svh ====
`ifndef TB_FIFO_CHECKS_SVH
`define TB_FIFO_CHECKS_SVH

// ---------------------------------------------------------------------------
// Compare tasks
// ---------------------------------------------------------------------------
task automatic check_data(input string what, input fifo_pkg::data_t got,
                          input fifo_pkg::data_t exp);
    check_total++;
    if (got !== exp) begin
        error_total++;
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_count(input string what, input fifo_pkg::cnt_t got,
                           input fifo_pkg::cnt_t exp);
    check_total++;
    if (got !== exp) begin
        error_total++;
        $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_word(input string what, input fifo_pkg::apb_word_t got,
                          input fifo_pkg::apb_word_t exp);
    check_total++;
    if (got !== exp) begin
        error_total++;
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    check_total++;
    if (got !== exp) begin
        error_total++;
        $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// ---------------------------------------------------------------------------
// APB transfers
// ---------------------------------------------------------------------------
// Setup phase, access phase, sampled in the middle of the access phase
task automatic read_reg(input logic [`APB_ADDR_WID-1:0] addr,
                        output fifo_pkg::apb_word_t data, output logic err);
    @(posedge rd_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge rd_clk);
    penable <= 1'b1;
    @(negedge rd_clk);
    check_flag("pready", pready, 1'b1);
    data = prdata;
    err  = pslverr;
    @(posedge rd_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

// Write lands on the edge that ends the access phase
task automatic write_reg(input logic [`APB_ADDR_WID-1:0] addr,
                         input fifo_pkg::apb_word_t data, output logic err);
    @(posedge rd_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge rd_clk);
    penable <= 1'b1;
    @(negedge rd_clk);
    check_flag("pready", pready, 1'b1);
    err = pslverr;
    @(posedge rd_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

`endif

// ==== sim/tb_fifo_core.sv ====
`timescale 1ns/1ps
`include "fifo_defines.svh"

module tb_fifo_core;

    // Whole run is about 600 cycles
    localparam int CYCLE_LIMIT = 4000;
    localparam int RAND_CYCLES = 300;
    localparam int FULL_N      = `FIFO_DEPTH + 1;

    logic                     rd_clk;
    logic                     local_rd_srst;
    logic                     wr;
    fifo_pkg::data_t          wr_data;
    logic                     wr_full;
    fifo_pkg::cnt_t           wr_count;
    logic                     wr_oflow;
    logic                     rd;
    logic                     rd_ack;
    fifo_pkg::data_t          rd_data;
    logic                     rd_empty;
    fifo_pkg::cnt_t           rd_count;
    logic                     rd_uflow;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`APB_ADDR_WID-1:0] paddr;
    fifo_pkg::apb_word_t      pwdata;
    fifo_pkg::apb_word_t      prdata;
    logic                     pready;
    logic                     pslverr;

    // Reference model state
    fifo_pkg::data_t model_q[$];
    logic            oflow_st;
    logic            uflow_st;
    int              check_total;
    int              error_total;
    int              test_total;
    int              test_err_base;
    int              cycle_cnt = 0;
    integer          seed;

    `include "tb_fifo_checks.svh"

    fifo_core u_dut (.*);

    always #4 rd_clk = ~rd_clk;

    // Expected REG_STATUS word for n stored words
    function automatic fifo_pkg::apb_word_t exp_status(input int n, input logic ov,
                                                       input logic un);
        fifo_pkg::apb_word_t w;
        w       = '0;
        w[3:0]  = fifo_pkg::cnt_t'(n);
        if (n >= 1) begin
            w[11:8] = fifo_pkg::cnt_t'(n - 1);
        end
        w[16]   = (n == FULL_N);
        w[17]   = (n == 0);
        w[24]   = ov;
        w[25]   = un;
        return w;
    endfunction

    task automatic expect_reg(input logic [`APB_ADDR_WID-1:0] addr,
                              input fifo_pkg::apb_word_t exp, input string what);
        fifo_pkg::apb_word_t data;
        logic                err;
        read_reg(addr, data, err);
        check_word(what, data, exp);
        check_flag({what, " pslverr"}, err, 1'b0);
    endtask

    task automatic push_random(input int count);
        repeat (count) begin
            @(posedge rd_clk);
            wr      <= 1'b1;
            wr_data <= fifo_pkg::data_t'($random(seed));
        end
        @(posedge rd_clk);
        wr <= 1'b0;
    endtask

    // Read until the model is empty, the monitor pops and compares
    task automatic drain_fifo();
        @(posedge rd_clk);
        wr <= 1'b0;
        rd <= 1'b1;
        while (model_q.size() != 0) begin
            @(posedge rd_clk);
        end
        rd <= 1'b0;
    endtask

    task automatic end_test(input string name);
        test_total++;
        $display("Test %0d, %s: %0d errors", test_total, name, error_total - test_err_base);
        test_err_base = error_total;
    endtask

    // ------------------------------------------------------------------------
    // Monitor, sampled mid cycle and applied at the next rising edge
    // ------------------------------------------------------------------------
    always @(negedge rd_clk) begin : monitor
        int n;
        n = model_q.size();
        if (!local_rd_srst) begin
            check_count("rd_count", rd_count, fifo_pkg::cnt_t'(n));
            check_flag("wr_full", wr_full, n == FULL_N);
            check_flag("wr_oflow", wr_oflow, wr && (n == FULL_N));
            if (n == 0) begin
                check_flag("rd_empty", rd_empty, 1'b1);
            end
            if (rd && rd_ack) begin
                if (n == 0) begin
                    error_total++;
                    $display("[ERROR] %0t ns: rd_ack high with no word stored", $time);
                end else begin
                    check_data("rd_data", rd_data, model_q[0]);
                    void'(model_q.pop_front());
                end
            end
            if (rd && (n == 0)) begin
                check_flag("rd_uflow", rd_uflow, 1'b1);
                uflow_st = 1'b1;
            end else if (!rd) begin
                check_flag("rd_uflow", rd_uflow, 1'b0);
            end
            // Write while holding DEPTH+1 words is dropped
            if (wr && (n < FULL_N)) begin
                model_q.push_back(wr_data);
            end else if (wr) begin
                oflow_st = 1'b1;
            end
        end
    end

    always @(posedge rd_clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the DUT stopped responding", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic   err;
        integer r;

        seed          = 69722;
        oflow_st      = 1'b0;
        uflow_st      = 1'b0;
        check_total   = 0;
        error_total   = 0;
        test_total    = 0;
        test_err_base = 0;
        rd_clk        = 1'b0;
        local_rd_srst = 1'b1;
        wr            = 1'b0;
        wr_data       = '0;
        rd            = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        repeat (4) @(posedge rd_clk);
        local_rd_srst <= 1'b0;

        @(negedge rd_clk);
        check_flag("rd_empty after reset", rd_empty, 1'b1);
        check_flag("wr_full after reset", wr_full, 1'b0);
        check_flag("rd_ack after reset", rd_ack, 1'b0);
        check_flag("pslverr after reset", pslverr, 1'b0);
        expect_reg(fifo_pkg::REG_INFO, 32'h0000_0007, "REG_INFO");
        expect_reg(fifo_pkg::REG_DEPTH, fifo_pkg::apb_word_t'(`FIFO_DEPTH), "REG_DEPTH");
        expect_reg(fifo_pkg::REG_STATUS, exp_status(0, oflow_st, uflow_st), "REG_STATUS");
        end_test("reset and constants");

        // Fill-heavy first half, drain-heavy second half
        for (int i = 0; i < RAND_CYCLES; i++) begin
            @(posedge rd_clk);
            r = $random(seed);
            wr      <= (i < RAND_CYCLES / 2) ? (r[1:0] != 2'b00) : (r[1:0] == 2'b00);
            rd      <= (i < RAND_CYCLES / 2) ? (r[3:2] == 2'b00) : (r[3:2] != 2'b00);
            wr_data <= r[31:16];
        end
        drain_fifo();
        end_test("ordered data");

        write_reg(fifo_pkg::REG_STATUS, '0, err);
        oflow_st = 1'b0;
        uflow_st = 1'b0;
        push_random(FULL_N);
        repeat (3) @(posedge rd_clk);
        @(negedge rd_clk);
        check_flag("wr_full when filled", wr_full, 1'b1);
        check_flag("rd_empty when filled", rd_empty, 1'b0);
        check_count("wr_count when filled", wr_count, fifo_pkg::cnt_t'(`FIFO_DEPTH));
        expect_reg(fifo_pkg::REG_STATUS, exp_status(FULL_N, oflow_st, uflow_st),
                   "REG_STATUS full");
        // Monitor expects wr_oflow on this one
        push_random(1);
        expect_reg(fifo_pkg::REG_STATUS, exp_status(FULL_N, oflow_st, uflow_st),
                   "REG_STATUS oflow");
        drain_fifo();
        expect_reg(fifo_pkg::REG_STATUS, exp_status(0, oflow_st, uflow_st),
                   "REG_STATUS drained");
        end_test("fill and overflow");

        @(posedge rd_clk);
        rd <= 1'b1;
        @(posedge rd_clk);
        rd <= 1'b0;
        expect_reg(fifo_pkg::REG_STATUS, exp_status(0, oflow_st, uflow_st), "REG_STATUS uflow");
        write_reg(fifo_pkg::REG_STATUS, 32'hFFFF_FFFF, err);
        check_flag("pslverr on REG_STATUS write", err, 1'b0);
        oflow_st = 1'b0;
        uflow_st = 1'b0;
        expect_reg(fifo_pkg::REG_STATUS, exp_status(0, oflow_st, uflow_st),
                   "REG_STATUS cleared");
        end_test("underflow");

        push_random(5);
        repeat (3) @(posedge rd_clk);
        expect_reg(fifo_pkg::REG_STATUS, exp_status(5, oflow_st, uflow_st),
                   "REG_STATUS partial");
        write_reg(fifo_pkg::REG_CONTROL, 32'h0000_0001, err);
        // Soft reset edge
        @(posedge rd_clk);
        model_q.delete();
        @(negedge rd_clk);
        check_flag("rd_empty after soft reset", rd_empty, 1'b1);
        check_count("wr_count after soft reset", wr_count, '0);
        expect_reg(fifo_pkg::REG_STATUS, exp_status(0, oflow_st, uflow_st),
                   "REG_STATUS soft reset");
        push_random(2);
        drain_fifo();
        end_test("soft reset");

        // Only offsets on a word boundary are registers
        for (int i = 0; i < 16; i++) begin
            fifo_pkg::apb_word_t data;
            read_reg(`APB_ADDR_WID'(i), data, err);
            check_flag("pslverr on read", err, (i % 4) != 0);
        end
        write_reg(`APB_ADDR_WID'(6), 32'h0000_0001, err);
        check_flag("pslverr on bad write", err, 1'b1);
        end_test("bad address");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_total, check_total,
                 error_total);
        if (error_total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_fifo_core

// ==== compile.f ====
+incdir+source
+incdir+sim
source/fifo_pkg.sv
source/fifo_reg_decode.sv
source/fifo_ctrl.sv
source/fifo_mem.sv
source/fifo_fwft_out.sv
source/fifo_core.sv
sim/tb_fifo_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_fifo_core
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and pass only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
